/* Bender.yml */
package:
  name: cd_host_bridge

sources:
  - target: any(rtl, test)
    files:
      - verilog/cd_link_pkg.sv
      - verilog/cd_data_pkg.sv
      - verilog/cd_msg_sender.sv
      - verilog/cd_status_receiver.sv
      - verilog/cd_sector_loader.sv
      - verilog/cd_host_bridge.sv

  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_cd_host_bridge.sv

/* cd_host_bridge.f */
+incdir+sim
verilog/cd_link_pkg.sv
verilog/cd_data_pkg.sv
verilog/cd_msg_sender.sv
verilog/cd_status_receiver.sv
verilog/cd_sector_loader.sv
verilog/cd_host_bridge.sv
sim/tb_cd_host_bridge.sv

/* sim/tb_cd_checks.svh */
/*
 * CD host bridge testbench support
 * Clock, pseudo-random payload source, watchdog and the compare
 * tasks, one for each kind of DUT result.
 */

`ifndef TB_CD_CHECKS_SVH
`define TB_CD_CHECKS_SVH

	//////////////////////////////////////////////////
	// Clock and watchdog

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		fail_run("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////
	// Payload source

	logic [15:0] lfsr_state = 16'd81;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [95:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[94:0], lfsr_state[0]};
		end
	endtask

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_frame(input string name, input cd_link_pkg::link_frame_t act,
			input cd_link_pkg::link_frame_t exp);
		if (act !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
				$time, name, act, exp));
		end
	endtask

	task automatic check_status(input string name, input cd_link_pkg::cd_status_t act,
			input cd_link_pkg::cd_status_t exp);
		if (act !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
				$time, name, act, exp));
		end
	endtask

	task automatic check_byte(input string name, input cd_data_pkg::cd_byte_t act,
			input cd_data_pkg::cd_byte_t exp);
		if (act !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
				$time, name, act, exp));
		end
	endtask

	task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] act,
			input logic [COUNT_WIDTH-1:0] exp);
		if (act !== exp) begin
			fail_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
				$time, name, act, exp));
		end
	endtask

`endif

/* sim/tb_cd_host_bridge.sv */
/*
 * CD host bridge testbench
 * Directed tests of the outgoing frames, the status receive path,
 * a sector download and the reset behavior.
 */

`timescale 1ns/100ps

module tb_cd_host_bridge;

	localparam int COUNT_WIDTH  = 8;
	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 4;
	localparam int WAIT_LIMIT   = 12;
	localparam int SECTOR_LEN   = 5;
	// Clock budget of the reset and of each test
	localparam int TEST_CYCLES  = RESET_CYCLES + 20 + 50 + 30 + 50 + 30;

	logic                       clk_sys;
	logic                       reset;
	cd_link_pkg::cmd_payload_t  i_comm;
	logic                       i_comm_send;
	cd_link_pkg::dout_payload_t i_dout;
	logic                       i_dout_send;
	logic                       i_reset_req;
	logic                       i_fast_seek;
	cd_link_pkg::link_frame_t   o_to_host;
	logic [COUNT_WIDTH-1:0]     o_comm_cnt;
	cd_link_pkg::link_frame_t   i_from_host;
	cd_link_pkg::cd_status_t    o_stat;
	logic                       o_stat_get;
	logic                       o_dout_req;
	logic [COUNT_WIDTH-1:0]     o_stat_cnt;
	logic                       i_dl_active;
	logic                       i_dl_wr;
	cd_data_pkg::dl_word_t      i_dl_word;
	cd_data_pkg::cd_byte_t      o_cd_byte;
	logic                       o_cd_wr;
	logic                       o_cd_dm;
	logic                       o_dl_busy;

	// Expected state and observed events
	cd_link_pkg::link_frame_t exp_frame;
	cd_link_pkg::link_frame_t host_frame;
	logic [COUNT_WIDTH-1:0]   exp_comm_cnt;
	logic [COUNT_WIDTH-1:0]   exp_stat_cnt;
	int                       stat_get_seen = 0;
	int                       dout_req_seen = 0;
	cd_data_pkg::cd_byte_t    wr_bytes[$];

	`include "tb_cd_checks.svh"

	cd_host_bridge #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) UUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.i_comm      (i_comm),
		.i_comm_send (i_comm_send),
		.i_dout      (i_dout),
		.i_dout_send (i_dout_send),
		.i_reset_req (i_reset_req),
		.i_fast_seek (i_fast_seek),
		.o_to_host   (o_to_host),
		.o_comm_cnt  (o_comm_cnt),
		.i_from_host (i_from_host),
		.o_stat      (o_stat),
		.o_stat_get  (o_stat_get),
		.o_dout_req  (o_dout_req),
		.o_stat_cnt  (o_stat_cnt),
		.i_dl_active (i_dl_active),
		.i_dl_wr     (i_dl_wr),
		.i_dl_word   (i_dl_word),
		.o_cd_byte   (o_cd_byte),
		.o_cd_wr     (o_cd_wr),
		.o_cd_dm     (o_cd_dm),
		.o_dl_busy   (o_dl_busy)
	);

	// Pulses and byte writes sampled mid-cycle
	always @(negedge clk_sys) begin
		if (o_stat_get) stat_get_seen++;
		if (o_dout_req) dout_req_seen++;
		if (o_cd_wr) wr_bytes.push_back(o_cd_byte);
	end

	//////////////////////////////////////////////////
	// Console to host

	task automatic wait_toggle(input logic old);
		int n;
		n = 0;
		while (o_to_host.toggle === old) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) fail_run("no frame from the DUT after a console request");
		end
	endtask

	// Raise the given requests and expect exactly one new frame
	task automatic request_frame(input logic comm, input logic dout, input logic rst);
		logic old;
		old = exp_frame.toggle;
		exp_frame.toggle = ~old;
		@(posedge clk_sys);
		i_comm_send <= comm;
		i_dout_send <= dout;
		i_reset_req <= rst;
		wait_toggle(old);
		check_frame("o_to_host", o_to_host, exp_frame);
		check_count("o_comm_cnt", o_comm_cnt, exp_comm_cnt);
		repeat (4) @(negedge clk_sys);
		check_frame("o_to_host while held", o_to_host, exp_frame);
		check_count("o_comm_cnt while held", o_comm_cnt, exp_comm_cnt);
		@(posedge clk_sys);
		i_comm_send <= 1'b0;
		i_dout_send <= 1'b0;
		i_reset_req <= 1'b0;
	endtask

	task automatic command_frame();
		logic [95:0] bits;
		draw_bits(96, bits);
		@(posedge clk_sys);
		i_comm      <= bits;
		i_fast_seek <= 1'b1;
		exp_frame.payload = bits;
		exp_frame.kind = {1'b1, cd_link_pkg::KIND_COMMAND[14:0]};
		exp_comm_cnt++;
		request_frame(1'b1, 1'b0, 1'b0);
	endtask

	task automatic dout_and_reset_frames();
		logic [95:0] bits;
		draw_bits(80, bits);
		@(posedge clk_sys);
		i_dout <= bits[79:0];
		exp_frame.payload[79:0] = bits[79:0];
		exp_frame.kind = cd_link_pkg::KIND_DATAOUT;
		request_frame(1'b0, 1'b1, 1'b0);
		exp_frame.kind = cd_link_pkg::KIND_RESET;
		request_frame(1'b0, 1'b0, 1'b1);
		// Command and reset together lose the reset edge
		draw_bits(96, bits);
		@(posedge clk_sys);
		i_comm      <= bits;
		i_fast_seek <= 1'b0;
		exp_frame.payload = bits;
		exp_frame.kind = {1'b0, cd_link_pkg::KIND_COMMAND[14:0]};
		exp_comm_cnt++;
		request_frame(1'b1, 1'b0, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// Host to console

	task automatic host_status(input logic dout_flag);
		logic [95:0]             bits;
		cd_link_pkg::cd_status_t exp_stat;
		int                      get_before;
		int                      dout_before;
		int                      n;
		draw_bits(96, bits);
		bits[cd_link_pkg::STATUS_FLAG_BIT] = dout_flag;
		exp_stat.stat = bits[7:0];
		exp_stat.msg = bits[15:8];
		get_before = stat_get_seen;
		dout_before = dout_req_seen;
		host_frame.payload = bits;
		host_frame.toggle = ~host_frame.toggle;
		exp_stat_cnt++;
		@(posedge clk_sys);
		i_from_host <= host_frame;
		n = 0;
		while (!o_stat_get && !o_dout_req) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) fail_run("no status pulse after a new host frame");
		end
		check_status("o_stat", o_stat, exp_stat);
		repeat (3) @(posedge clk_sys);
		check_count("o_stat_get pulses", COUNT_WIDTH'(stat_get_seen - get_before), !dout_flag);
		check_count("o_dout_req pulses", COUNT_WIDTH'(dout_req_seen - dout_before), dout_flag);
		check_count("o_stat_cnt", o_stat_cnt, exp_stat_cnt);
	endtask

	//////////////////////////////////////////////////
	// Sector download

	// Busy lasts two clocks for each byte the word delivers
	task automatic send_word(input cd_data_pkg::dl_word_t w, input int exp_busy);
		int n;
		@(posedge clk_sys);
		i_dl_wr   <= 1'b1;
		i_dl_word <= w;
		@(posedge clk_sys);
		i_dl_wr <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (o_dl_busy) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) fail_run("download stayed busy after a word");
		end
		check_count("o_dl_busy cycles", COUNT_WIDTH'(n), COUNT_WIDTH'(exp_busy));
	endtask

	task automatic sector_download();
		cd_data_pkg::sector_header_t hdr;
		cd_data_pkg::dl_word_t       words[3];
		cd_data_pkg::cd_byte_t       exp_byte;
		logic [95:0]                 bits;
		int                          left;
		wr_bytes.delete();
		@(posedge clk_sys);
		i_dl_active <= 1'b1;
		hdr.data_mode = 1'b1;
		hdr.len = 15'(SECTOR_LEN);
		send_word(hdr, 0);
		draw_bits(48, bits);
		left = SECTOR_LEN;
		for (int i = 0; i < 3; i++) begin
			words[i] = bits[16*i +: 16];
			send_word(words[i], (left >= 2) ? 4 : 2 * left);
			left = left - 2;
		end
		@(posedge clk_sys);
		i_dl_active <= 1'b0;
		check_count("o_cd_wr pulses", COUNT_WIDTH'(wr_bytes.size()), SECTOR_LEN);
		// Low byte first and a lone low byte at the odd end
		for (int k = 0; k < SECTOR_LEN; k++) begin
			exp_byte = k[0] ? words[k / 2][15:8] : words[k / 2][7:0];
			check_byte($sformatf("o_cd_byte write %0d", k), wr_bytes[k], exp_byte);
		end
		check_count("o_cd_dm", COUNT_WIDTH'(o_cd_dm), 1);
	endtask

	//////////////////////////////////////////////////
	// Reset with a pending host toggle

	task automatic reset_with_pending_toggle();
		int events_before;
		// One more frame leaves the outgoing toggle at one
		exp_frame.kind = cd_link_pkg::KIND_RESET;
		request_frame(1'b0, 1'b0, 1'b1);
		events_before = stat_get_seen + dout_req_seen + wr_bytes.size();
		@(posedge clk_sys);
		reset <= 1'b1;
		@(posedge clk_sys);
		host_frame.toggle = ~host_frame.toggle;
		i_from_host <= host_frame;
		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		reset <= 1'b0;
		exp_comm_cnt = '0;
		exp_stat_cnt = '0;
		repeat (8) @(posedge clk_sys);
		check_count("o_comm_cnt", o_comm_cnt, exp_comm_cnt);
		check_count("o_stat_cnt", o_stat_cnt, exp_stat_cnt);
		check_count("pulses and writes after reset",
			COUNT_WIDTH'(stat_get_seen + dout_req_seen + wr_bytes.size() - events_before), 0);
		check_frame("o_to_host", o_to_host, exp_frame);
	endtask

	initial begin
		reset       = 1'b1;
		i_comm      = '0;
		i_comm_send = 1'b0;
		i_dout      = '0;
		i_dout_send = 1'b0;
		i_reset_req = 1'b0;
		i_fast_seek = 1'b0;
		host_frame  = '0;
		i_from_host = '0;
		i_dl_active = 1'b0;
		i_dl_wr     = 1'b0;
		i_dl_word   = '0;
		exp_comm_cnt = '0;
		exp_stat_cnt = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		exp_frame = o_to_host;
		check_count("o_comm_cnt", o_comm_cnt, exp_comm_cnt);
		check_count("o_stat_cnt", o_stat_cnt, exp_stat_cnt);
		command_frame();
		dout_and_reset_frames();
		host_status(1'b0);
		host_status(1'b1);
		sector_download();
		reset_with_pending_toggle();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* verilog/cd_data_pkg.sv */
/*
 * CD sector download definitions
 * Header word layout and the byte and word types used when a
 * downloaded sector is split into console byte writes.
 */

package cd_data_pkg;

	// Number of bytes in a sector
	typedef logic [14:0] sector_len_t;

	// First word of a download
	typedef struct packed {
		logic        data_mode;
		sector_len_t len;
	} sector_header_t;

	// One byte to the console
	typedef logic [7:0] cd_byte_t;

	// One word from the host
	typedef logic [15:0] dl_word_t;

endpackage

/* verilog/cd_host_bridge.sv */
/*
 * CD host bridge
 * Top of the CD link. Console requests go out to the host as
 * frames, host status frames come back as pulses, and sector
 * downloads are turned into console byte writes.
 */

`timescale 1ns/100ps

module cd_host_bridge #(
	parameter int COUNT_WIDTH = 8
) (
	input  logic                       clk_sys,
	input  logic                       reset,

	// Console to host
	input  cd_link_pkg::cmd_payload_t  i_comm,
	input  logic                       i_comm_send,
	input  cd_link_pkg::dout_payload_t i_dout,
	input  logic                       i_dout_send,
	input  logic                       i_reset_req,
	input  logic                       i_fast_seek,
	output cd_link_pkg::link_frame_t   o_to_host,
	output logic [COUNT_WIDTH-1:0]     o_comm_cnt,

	// Host to console
	input  cd_link_pkg::link_frame_t   i_from_host,
	output cd_link_pkg::cd_status_t    o_stat,
	output logic                       o_stat_get,
	output logic                       o_dout_req,
	output logic [COUNT_WIDTH-1:0]     o_stat_cnt,

	// Sector download
	input  logic                       i_dl_active,
	input  logic                       i_dl_wr,
	input  cd_data_pkg::dl_word_t      i_dl_word,
	output cd_data_pkg::cd_byte_t      o_cd_byte,
	output logic                       o_cd_wr,
	output logic                       o_cd_dm,
	output logic                       o_dl_busy
);

	//////////////////////////////////////////////////
	// Link blocks

	cd_msg_sender #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_sender (
		.i_clk_sys   (clk_sys),
		.i_reset     (reset),
		.i_comm      (i_comm),
		.i_comm_send (i_comm_send),
		.i_dout      (i_dout),
		.i_dout_send (i_dout_send),
		.i_reset_req (i_reset_req),
		.i_fast_seek (i_fast_seek),
		.o_to_host   (o_to_host),
		.o_comm_cnt  (o_comm_cnt)
	);

	cd_status_receiver #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_receiver (
		.i_clk_sys   (clk_sys),
		.i_reset     (reset),
		.i_from_host (i_from_host),
		.o_stat      (o_stat),
		.o_stat_get  (o_stat_get),
		.o_dout_req  (o_dout_req),
		.o_stat_cnt  (o_stat_cnt)
	);

	cd_sector_loader u_loader (
		.i_clk_sys   (clk_sys),
		.i_reset     (reset),
		.i_dl_active (i_dl_active),
		.i_dl_wr     (i_dl_wr),
		.i_dl_word   (i_dl_word),
		.o_cd_byte   (o_cd_byte),
		.o_cd_wr     (o_cd_wr),
		.o_cd_dm     (o_cd_dm),
		.o_dl_busy   (o_dl_busy)
	);

endmodule

/* verilog/cd_link_pkg.sv */
/*
 * CD host link definitions
 * Frame layout shared by both directions of the link between the
 * console CD interface and the host, plus the status word and the
 * message kinds carried in outgoing frames.
 */

package cd_link_pkg;

	//////////////////////////////////////////////////
	// Payloads

	// Command packet, 12 bytes
	typedef logic [95:0] cmd_payload_t;

	// Data-out packet, 10 bytes, sits in the low payload bits
	typedef logic [79:0] dout_payload_t;

	//////////////////////////////////////////////////
	// Message kinds

	// Bit 15 of a command kind carries the fast-seek flag
	typedef logic [15:0] msg_kind_t;

	localparam msg_kind_t KIND_COMMAND = 16'h0000;
	localparam msg_kind_t KIND_DATAOUT = 16'h0001;
	localparam msg_kind_t KIND_RESET   = 16'h00ff;

	//////////////////////////////////////////////////
	// Frames and status

	// Toggle on top, a change marks a new frame
	typedef struct packed {
		logic         toggle;
		msg_kind_t    kind;
		cmd_payload_t payload;
	} link_frame_t;

	typedef struct packed {
		logic [7:0] msg;
		logic [7:0] stat;
	} cd_status_t;

	// Set in a host frame for a data-out request
	localparam int STATUS_FLAG_BIT = 16;

endpackage

/* verilog/cd_msg_sender.sv */
/*
 * CD message sender
 * Turns rising edges of the console request lines into frames for
 * the host. Command beats data-out beats reset. Each accepted edge
 * rewrites part of the frame and inverts its toggle bit.
 */

`timescale 1ns/100ps

module cd_msg_sender #(
	parameter int COUNT_WIDTH = 8
) (
	input  logic                       i_clk_sys,
	input  logic                       i_reset,

	input  cd_link_pkg::cmd_payload_t  i_comm,
	input  logic                       i_comm_send,
	input  cd_link_pkg::dout_payload_t i_dout,
	input  logic                       i_dout_send,
	input  logic                       i_reset_req,
	input  logic                       i_fast_seek,

	output cd_link_pkg::link_frame_t   o_to_host,
	output logic [COUNT_WIDTH-1:0]     o_comm_cnt
);

	localparam int DOUT_BITS = $bits(cd_link_pkg::dout_payload_t);

	// Previous request levels
	logic comm_prev;
	logic dout_prev;
	logic rst_prev;

	logic comm_edge;
	logic dout_edge;
	logic rst_edge;
	logic send_any;

	// Toggle starts at zero and survives reset
	cd_link_pkg::link_frame_t frame_q = '0;
	logic [COUNT_WIDTH-1:0]   comm_cnt_q;

	assign comm_edge = i_comm_send & ~comm_prev;
	assign dout_edge = i_dout_send & ~dout_prev;
	assign rst_edge  = i_reset_req & ~rst_prev;
	assign send_any  = ~i_reset & (comm_edge | dout_edge | rst_edge);

	// Track levels during reset too, so a held request sends nothing
	always_ff @(posedge i_clk_sys) begin
		comm_prev <= i_comm_send;
		dout_prev <= i_dout_send;
		rst_prev  <= i_reset_req;
	end

	//////////////////////////////////////////////////
	// Frame build with partial field updates

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			comm_cnt_q <= '0;
		end else begin
			if (comm_edge) begin
				frame_q.payload <= i_comm;
				frame_q.kind    <= {i_fast_seek, cd_link_pkg::KIND_COMMAND[14:0]};
				comm_cnt_q      <= comm_cnt_q + COUNT_WIDTH'(1);
			end else if (dout_edge) begin
				frame_q.payload[DOUT_BITS-1:0] <= i_dout;
				frame_q.kind                   <= cd_link_pkg::KIND_DATAOUT;
			end else if (rst_edge) begin
				frame_q.kind <= cd_link_pkg::KIND_RESET;
			end

			if (send_any) begin
				frame_q.toggle <= ~frame_q.toggle;
			end
		end
	end

	assign o_to_host  = frame_q;
	assign o_comm_cnt = comm_cnt_q;

	//////////////////////////////////////////////////
	// Checks

	// Toggle holds unless a request line rose in the clock before
	a_toggle_needs_edge: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		!($rose(i_comm_send) || $rose(i_dout_send) || $rose(i_reset_req))
			|=> $stable(o_to_host.toggle)
	) else $error("toggle changed without a request edge");

endmodule

/* verilog/cd_sector_loader.sv */
/*
 * CD sector loader
 * Takes the host download of a sector. The first word is a header
 * with the data mode and byte count. Each later word is split into
 * two console byte writes, low byte first, with the write strobe
 * high and low for one clock each.
 */

`timescale 1ns/100ps

module cd_sector_loader (
	input  logic                  i_clk_sys,
	input  logic                  i_reset,

	input  logic                  i_dl_active,
	input  logic                  i_dl_wr,
	input  cd_data_pkg::dl_word_t i_dl_word,

	output cd_data_pkg::cd_byte_t o_cd_byte,
	output logic                  o_cd_wr,
	output logic                  o_cd_dm,
	output logic                  o_dl_busy
);

	cd_data_pkg::sector_header_t hdr;

	logic                     active_prev;
	logic                     dl_start;
	logic                     head_q;
	logic                     dm_q;
	cd_data_pkg::sector_len_t len_q;
	cd_data_pkg::sector_len_t cnt_q;
	cd_data_pkg::dl_word_t    word_q;
	logic                     write_q;
	logic                     byte_hi_q;
	logic                     cd_wr_q;

	assign hdr      = i_dl_word;
	assign dl_start = i_dl_active & ~active_prev;

	always_ff @(posedge i_clk_sys) begin
		active_prev <= i_dl_active;
	end

	//////////////////////////////////////////////////
	// Header, byte count and write sequencer

	always_ff @(posedge i_clk_sys) begin
		if (i_reset || dl_start) begin
			head_q    <= 1'b0;
			dm_q      <= 1'b0;
			len_q     <= '0;
			cnt_q     <= '0;
			write_q   <= 1'b0;
			byte_hi_q <= 1'b0;
			cd_wr_q   <= 1'b0;
		end else begin
			if (i_dl_wr) begin
				if (!head_q) begin
					dm_q   <= hdr.data_mode;
					len_q  <= hdr.len;
					cnt_q  <= '0;
					head_q <= 1'b1;
				end else if (cnt_q < len_q) begin
					write_q   <= 1'b1;
					byte_hi_q <= 1'b0;
				end
			end

			// Strobe up one clock, down the next
			if (write_q) begin
				if (!cd_wr_q) begin
					cd_wr_q <= 1'b1;
				end else begin
					cd_wr_q   <= 1'b0;
					byte_hi_q <= ~byte_hi_q;
					cnt_q     <= cnt_q + 15'd1;
					// Odd last byte ends the word early
					if (byte_hi_q || (cnt_q + 15'd1) >= len_q) begin
						write_q <= 1'b0;
					end
				end
			end
		end
	end

	// Word held while its two bytes go out
	always_ff @(posedge i_clk_sys) begin
		if (i_dl_wr && head_q && (cnt_q < len_q)) begin
			word_q <= i_dl_word;
		end
	end

	assign o_cd_byte = byte_hi_q ? word_q[15:8] : word_q[7:0];
	assign o_cd_wr   = cd_wr_q;
	assign o_cd_dm   = dm_q;
	assign o_dl_busy = write_q;

	//////////////////////////////////////////////////
	// Checks

	a_wr_gap: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		o_cd_wr |=> !o_cd_wr
	) else $error("write strobe high on two clocks");

	// Host must wait for the word in flight
	a_no_wr_when_busy: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		!(i_dl_wr && o_dl_busy)
	) else $error("download word while busy");

endmodule

/* verilog/cd_status_receiver.sv */
/*
 * CD status receiver
 * Watches the toggle bit of the host frame. A change latches the
 * status word and gives one pulse, either status-get or a data-out
 * request, one clock later. Frames are counted.
 */

`timescale 1ns/100ps

module cd_status_receiver #(
	parameter int COUNT_WIDTH = 8
) (
	input  logic                     i_clk_sys,
	input  logic                     i_reset,

	input  cd_link_pkg::link_frame_t i_from_host,

	output cd_link_pkg::cd_status_t  o_stat,
	output logic                     o_stat_get,
	output logic                     o_dout_req,
	output logic [COUNT_WIDTH-1:0]   o_stat_cnt
);

	logic                    toggle_seen;
	logic                    new_frame;
	logic                    is_dout;
	cd_link_pkg::cd_status_t stat_q;
	logic                    stat_get_q;
	logic                    dout_req_q;
	logic [COUNT_WIDTH-1:0]  stat_cnt_q;

	assign new_frame = i_from_host.toggle != toggle_seen;
	assign is_dout   = i_from_host.payload[cd_link_pkg::STATUS_FLAG_BIT];

	// Reset takes the current toggle, so no frame is seen
	always_ff @(posedge i_clk_sys) begin
		stat_get_q <= 1'b0;
		dout_req_q <= 1'b0;
		if (i_reset) begin
			toggle_seen <= i_from_host.toggle;
			stat_cnt_q  <= '0;
		end else if (new_frame) begin
			toggle_seen <= i_from_host.toggle;
			stat_get_q  <= ~is_dout;
			dout_req_q  <= is_dout;
			stat_cnt_q  <= stat_cnt_q + COUNT_WIDTH'(1);
		end
	end

	// Status word held until the next frame
	always_ff @(posedge i_clk_sys) begin
		if (!i_reset && new_frame) begin
			stat_q <= cd_link_pkg::cd_status_t'(i_from_host.payload[15:0]);
		end
	end

	assign o_stat     = stat_q;
	assign o_stat_get = stat_get_q;
	assign o_dout_req = dout_req_q;
	assign o_stat_cnt = stat_cnt_q;

	a_one_pulse: assert property (
		@(posedge i_clk_sys) disable iff (i_reset)
		!(o_stat_get && o_dout_req)
	) else $error("status-get and data-out request together");

endmodule
